/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_motor_ctrl
RTL_TOP   ?= motor_ctrl_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

RTL_FILES := $(filter src/%,$(shell cat $(FLIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* src/axis_channel.sv */
module axis_channel (
    input  logic           sysclk,
    input  logic           rst,
    input  logic           cmd_we,          // write strobe for this axis
    input  qla_pkg::cur_t  cmd_wdata,
    input  qla_pkg::cur_t  cur_fb,          // measured current from ADC
    input  logic           clear_disable,   // power or amp enable command
    output qla_pkg::cur_t  cur_cmd,         // commanded current
    output logic           amp_disable      // latched over-current trip
);

    import qla_pkg::*;

    cur_t        fb_mag;      // |feedback - midscale|
    cur_t        cmd_mag;     // |command - midscale|
    cur_lim_t    limit;       // trip threshold
    logic        over;        // this cycle is over the limit
    safety_cnt_t over_cnt;    // consecutive over-current cycles

    // ------------------------------------------------------------------------
    // commanded current register
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cur_cmd <= CUR_MIDSCALE;   // zero current out of reset
        end else if (cmd_we) begin
            cur_cmd <= cmd_wdata;
        end
    end

    // ------------------------------------------------------------------------
    // magnitudes around midscale
    // ------------------------------------------------------------------------
    always_comb begin
        if (cur_fb >= CUR_MIDSCALE) begin
            fb_mag = cur_fb - CUR_MIDSCALE;
        end else begin
            fb_mag = CUR_MIDSCALE - cur_fb;
        end
        if (cur_cmd >= CUR_MIDSCALE) begin
            cmd_mag = cur_cmd - CUR_MIDSCALE;
        end else begin
            cmd_mag = CUR_MIDSCALE - cur_cmd;
        end
    end

    // 2*|cmd| + margin, two extra bits so the sum never wraps
    assign limit = cur_lim_t'({cmd_mag, 1'b0}) + cur_lim_t'(SAFETY_MARGIN);
    assign over  = cur_lim_t'(fb_mag) > limit;    // equal is still fine

    // ------------------------------------------------------------------------
    // consecutive counter and trip latch
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst || clear_disable) begin
            over_cnt    <= '0;        // clear beats a trip in the same cycle
            amp_disable <= 1'b0;
        end else if (over) begin
            if (over_cnt == safety_cnt_t'(SAFETY_CYCLES - 1)) begin
                amp_disable <= 1'b1;  // trips on the Nth hit in a row
            end else begin
                over_cnt <= over_cnt + 1'b1;
            end
        end else begin
            over_cnt <= '0;           // streak broken
        end
    end

    // once tripped only reset or an enable command may re-arm the amplifier
    a_disable_sticky: assert property (
        @(posedge sysclk)
        $fell(amp_disable) |-> $past(rst || clear_disable)
    ) else $error("amp_disable dropped without rst or clear_disable");

endmodule

/* src/cmd_write_decode.sv */
module cmd_write_decode (
    input  logic                 sysclk,
    input  logic                 rst,
    input  logic                 reg_wen,     // single cycle host write
    input  logic                 blk_wen,     // last write of a block
    input  qla_pkg::addr_t       reg_waddr,
    input  qla_pkg::data_t       reg_wdata,
    input  logic                 dac_busy,    // shifter still sending
    output qla_pkg::axis_mask_t  cmd_we,      // one-hot axis write strobe
    output qla_pkg::cur_t        cmd_wdata,   // shared by all axes
    output logic                 dac_start    // one cycle kick to the shifter
);

    import qla_pkg::*;

    logic dac_hit;      // address is some axis's DAC_CTRL
    logic commit;       // block ends on a DAC write
    logic pending;      // commit waiting for the shifter

    // ------------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------------

    // channel 0 (board regs) and channels past NUM_AXES never match
    assign dac_hit = is_axis_addr(reg_waddr) &&
                     (addr_offset(reg_waddr) == OFF_DAC_CTRL);

    always_comb begin
        cmd_we = '0;
        if (reg_wen && dac_hit) begin
            cmd_we[addr_axis(reg_waddr)] = 1'b1;  // channel n -> bit n-1
        end
    end

    assign cmd_wdata = reg_wdata[CUR_W-1:0];  // upper half is don't care

    // ------------------------------------------------------------------------
    // DAC commit request
    // ------------------------------------------------------------------------
    assign commit = reg_wen && blk_wen && dac_hit;

    // fires as soon as the shifter is free
    assign dac_start = pending && !dac_busy;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (commit) begin
            pending <= 1'b1;      // new commit wins, extra ones just merge
        end else if (dac_start) begin
            pending <= 1'b0;      // handed to the shifter
        end
    end

    // shifter takes the kick at once and holds off further starts
    a_start_taken: assert property (
        @(posedge sysclk) disable iff (rst)
        dac_start |=> dac_busy && !dac_start
    ) else $error("dac_start not taken by the DAC shifter");

endmodule

/* src/dac_shifter.sv */
module dac_shifter (
    input  logic                                   sysclk,
    input  logic                                   rst,
    input  logic                                   dac_start,  // commit from decoder
    input  qla_pkg::cur_t [qla_pkg::NUM_AXES-1:0]  cur_cmd,    // live commands
    output logic                                   dac_busy,
    output logic                                   dac_sclk,
    output logic                                   dac_mosi,
    output logic                                   dac_csel    // active low
);

    import qla_pkg::*;

    dac_state_t                   state;
    axis_idx_t                    axis_idx;   // frame being sent
    dac_tick_t                    tick;       // sysclk count within SHIFT or GAP
    cur_t [NUM_AXES-1:0]          snap;       // commands frozen for this set
    logic [DAC_FRAME_BITS-1:0]    frame;
    dac_bit_t                     bit_sel;

    // ------------------------------------------------------------------------
    // sequencer: LOAD, then SHIFT + GAP once per axis
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state    <= IDLE;
            axis_idx <= '0;
            tick     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (dac_start) state <= LOAD;
                end
                LOAD: begin
                    axis_idx <= '0;           // axis 1 goes first
                    tick     <= '0;
                    state    <= SHIFT;
                end
                SHIFT: begin
                    if (tick == dac_tick_t'(DAC_SHIFT_TICKS - 1)) begin
                        tick  <= '0;
                        state <= GAP;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                GAP: begin
                    if (tick == dac_tick_t'(DAC_GAP_CYCLES - 1)) begin
                        tick <= '0;
                        if (axis_idx == axis_idx_t'(NUM_AXES - 1)) begin
                            state <= IDLE;    // busy drops after the last gap
                        end else begin
                            axis_idx <= axis_idx + 1'b1;
                            state    <= SHIFT;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (state == LOAD) snap <= cur_cmd;   // later host writes wait for next set
    end

    assign dac_busy = (state != IDLE);

    // cmd nibble, DAC channel, value; MSB first, one bit per sclk period
    assign frame   = {DAC_CMD_WRITE_UPDATE, 4'(axis_idx), snap[axis_idx]};
    assign bit_sel = dac_bit_t'(DAC_FRAME_BITS - 1) - dac_bit_t'(tick >> 1);

    // ------------------------------------------------------------------------
    // pin registers, one cycle behind the sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            dac_csel <= 1'b1;
            dac_sclk <= 1'b0;
            dac_mosi <= 1'b0;
        end else begin
            dac_csel <= (state != SHIFT);
            dac_sclk <= (state == SHIFT) && tick[0];          // rises mid bit
            dac_mosi <= (state == SHIFT) && frame[bit_sel];   // moves with sclk low
        end
    end

    a_csel_idle: assert property (
        @(posedge sysclk) disable iff (rst)
        !dac_busy |-> dac_csel
    ) else $error("dac_csel low while shifter idle");

    a_sclk_parked: assert property (
        @(posedge sysclk) disable iff (rst)
        dac_csel |-> !dac_sclk
    ) else $error("dac_sclk high outside a frame");

endmodule

/* src/motor_ctrl_top.sv */
module motor_ctrl_top (
    input  logic                                   sysclk,
    input  logic                                   rst,
    // host write bus
    input  logic                                   reg_wen,
    input  logic                                   blk_wen,
    input  qla_pkg::addr_t                         reg_waddr,
    input  qla_pkg::data_t                         reg_wdata,
    // host read bus
    input  qla_pkg::addr_t                         reg_raddr,
    output qla_pkg::data_t                         reg_rdata,
    // measured currents, axis 1 in the low slot
    input  qla_pkg::cur_t [qla_pkg::NUM_AXES-1:0]  cur_fb,
    // safety latch clear and status
    input  logic                                   pwr_enable_cmd,
    input  qla_pkg::axis_mask_t                    amp_enable_cmd,
    output qla_pkg::axis_mask_t                    amp_disable,
    // quad DAC serial port
    output logic                                   dac_sclk,
    output logic                                   dac_mosi,
    output logic                                   dac_csel
);

    import qla_pkg::*;

    axis_mask_t           cmd_we;       // per-axis command write
    cur_t                 cmd_wdata;
    logic                 dac_start;
    logic                 dac_busy;
    cur_t [NUM_AXES-1:0]  cur_cmd;      // all commanded currents
    axis_mask_t           clear_disable;

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    cmd_write_decode u_decode (
        .sysclk    (sysclk),
        .rst       (rst),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .dac_busy  (dac_busy),
        .cmd_we    (cmd_we),
        .cmd_wdata (cmd_wdata),
        .dac_start (dac_start)
    );

    // power enable re-arms every axis, amp enable only its own
    assign clear_disable = amp_enable_cmd | {NUM_AXES{pwr_enable_cmd}};

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        axis_channel u_chan (
            .sysclk        (sysclk),
            .rst           (rst),
            .cmd_we        (cmd_we[i]),
            .cmd_wdata     (cmd_wdata),
            .cur_fb        (cur_fb[i]),
            .clear_disable (clear_disable[i]),
            .cur_cmd       (cur_cmd[i]),
            .amp_disable   (amp_disable[i])
        );
    end

    // ------------------------------------------------------------------------
    // consumers of the channel state
    // ------------------------------------------------------------------------
    dac_shifter u_dac (
        .sysclk    (sysclk),
        .rst       (rst),
        .dac_start (dac_start),
        .cur_cmd   (cur_cmd),
        .dac_busy  (dac_busy),
        .dac_sclk  (dac_sclk),
        .dac_mosi  (dac_mosi),
        .dac_csel  (dac_csel)
    );

    reg_read_mux u_rd (
        .sysclk      (sysclk),
        .rst         (rst),
        .reg_raddr   (reg_raddr),
        .cur_fb      (cur_fb),
        .cur_cmd     (cur_cmd),
        .amp_disable (amp_disable),
        .reg_rdata   (reg_rdata)
    );

endmodule

/* src/qla_pkg.sv */
package qla_pkg;

    // ------------------------------------------------------------------------
    // board geometry and data widths
    // ------------------------------------------------------------------------
    localparam int NUM_AXES = 4;            // motor axes on the board
    localparam int CUR_W    = 16;           // ADC / DAC current word

    typedef logic [15:0]                   addr_t;       // host register address
    typedef logic [31:0]                   data_t;       // host register data
    typedef logic [CUR_W-1:0]              cur_t;        // offset binary current
    typedef logic [CUR_W+1:0]              cur_lim_t;    // 2*|cmd| + margin, no overflow
    typedef logic [NUM_AXES-1:0]           axis_mask_t;  // one bit per axis
    typedef logic [$clog2(NUM_AXES)-1:0]   axis_idx_t;   // zero-based axis number

    localparam cur_t CUR_MIDSCALE = 16'h8000;  // zero current

    // ------------------------------------------------------------------------
    // address map: [15:12] block, [7:4] channel, [3:0] offset
    // ------------------------------------------------------------------------
    localparam logic [3:0] ADDR_MAIN        = 4'h0;  // per-axis register block
    localparam logic [3:0] OFF_ADC_DATA     = 4'h0;  // measured current
    localparam logic [3:0] OFF_DAC_CTRL     = 4'h1;  // commanded current
    localparam logic [3:0] OFF_MOTOR_STATUS = 4'h4;  // amp enable + command

    // channel 1..NUM_AXES inside the main block
    function automatic logic is_axis_addr(addr_t addr);
        return (addr[15:12] == ADDR_MAIN) && (addr[7:4] != 4'd0) &&
               (addr[7:4] <= 4'(NUM_AXES));
    endfunction

    // channel field to axis index, channel 1 is axis 0
    function automatic axis_idx_t addr_axis(addr_t addr);
        return axis_idx_t'(addr[7:4] - 4'd1);
    endfunction

    function automatic logic [3:0] addr_offset(addr_t addr);
        return addr[3:0];
    endfunction

    // ------------------------------------------------------------------------
    // over-current safety check
    // ------------------------------------------------------------------------
    localparam cur_t SAFETY_MARGIN = 16'h0400;    // added to 2*|cmd|
    localparam int   SAFETY_CYCLES = 8;           // consecutive hits before latch

    typedef logic [$clog2(SAFETY_CYCLES)-1:0] safety_cnt_t;

    // ------------------------------------------------------------------------
    // quad DAC serial frame: cmd nibble, address nibble, 16 bit value
    // ------------------------------------------------------------------------
    localparam int         DAC_FRAME_BITS       = 24;
    localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'h3;  // write and update channel
    localparam int         DAC_SHIFT_TICKS      = 2 * DAC_FRAME_BITS;  // sclk = sysclk/2
    localparam int         DAC_GAP_CYCLES       = 2;     // csel high between frames

    typedef logic [$clog2(DAC_SHIFT_TICKS)-1:0] dac_tick_t;
    typedef logic [$clog2(DAC_FRAME_BITS)-1:0]  dac_bit_t;

    typedef enum logic [1:0] {
        IDLE,   // waiting for a commit
        LOAD,   // snapshot of all commands
        SHIFT,  // one frame on the wire
        GAP     // csel high between frames
    } dac_state_t;

endpackage

/* src/reg_read_mux.sv */
module reg_read_mux (
    input  logic                                   sysclk,
    input  logic                                   rst,
    input  qla_pkg::addr_t                         reg_raddr,
    input  qla_pkg::cur_t [qla_pkg::NUM_AXES-1:0]  cur_fb,
    input  qla_pkg::cur_t [qla_pkg::NUM_AXES-1:0]  cur_cmd,
    input  qla_pkg::axis_mask_t                    amp_disable,
    output qla_pkg::data_t                         reg_rdata
);

    import qla_pkg::*;

    axis_idx_t axis;       // addressed axis
    data_t     rd_word;    // next read value

    assign axis = addr_axis(reg_raddr);

    // ------------------------------------------------------------------------
    // per-axis word select
    // ------------------------------------------------------------------------
    always_comb begin
        rd_word = '0;                         // unmapped reads as zero
        if (is_axis_addr(reg_raddr)) begin
            case (addr_offset(reg_raddr))
                OFF_ADC_DATA: begin
                    rd_word = {16'h0000, cur_fb[axis]};
                end
                OFF_DAC_CTRL: begin
                    rd_word = {16'h0000, cur_cmd[axis]};
                end
                OFF_MOTOR_STATUS: begin
                    // bit 28 is amp enabled, the inverse of the trip latch
                    rd_word = {3'b000, ~amp_disable[axis], 12'h000, cur_cmd[axis]};
                end
                default: rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_word;             // valid one edge after raddr
        end
    end

endmodule

/* tb/motor_ctrl_checker.sv */
module motor_ctrl_checker (
    input  logic                 sysclk,
    input  logic                 rst,
    // DUT outputs under watch
    input  logic                 dac_sclk,
    input  logic                 dac_mosi,
    input  logic                 dac_csel,
    input  qla_pkg::axis_mask_t  amp_disable,
    input  qla_pkg::data_t       reg_rdata,
    // expectations from the stimulus side
    input  logic                 chk_read,     // compare reg_rdata this edge
    input  qla_pkg::data_t       exp_rdata,
    input  logic                 chk_dis,      // compare amp_disable this edge
    input  qla_pkg::axis_mask_t  exp_dis,
    input  logic                 push_dac,     // queue one expected frame set
    input  logic [63:0]          exp_dac,      // axis 1 command in the top 16 bits
    output int                   err_count,
    output int                   sets_done     // complete frame sets seen
);

    import qla_pkg::*;

    logic [63:0]               exp_q[$];     // frame sets still to come
    logic [63:0]               cur_set;
    logic                      sclk_q;
    logic                      csel_q;
    logic [DAC_FRAME_BITS-1:0] shreg;        // bits of the frame on the wire
    int                        nbits;
    int                        fidx;         // frame number inside the set

    task automatic check_frame();
        logic [15:0] want;
        if (nbits != DAC_FRAME_BITS) begin
            $display("frame %0d of a DAC set had %0d bits instead of %0d",
                     fidx, nbits, DAC_FRAME_BITS);
            err_count++;
        end
        if (fidx == 0) begin
            if (exp_q.size() == 0) begin
                $display("DAC frame set started with no set expected");
                err_count++;
                cur_set = {4{CUR_MIDSCALE}};
            end else begin
                cur_set = exp_q.pop_front();
            end
        end
        want = cur_set[63 - 16 * fidx -: 16];
        if (shreg[23:20] !== DAC_CMD_WRITE_UPDATE) begin
            $display("[ERROR] dac_cmd frame %0d exp %h got %h",
                     fidx, DAC_CMD_WRITE_UPDATE, shreg[23:20]);
            err_count++;
        end
        if (shreg[19:16] !== 4'(fidx)) begin
            $display("[ERROR] dac_addr exp %h got %h", 4'(fidx), shreg[19:16]);
            err_count++;
        end
        if (shreg[15:0] !== want) begin
            $display("[ERROR] dac_data axis %0d exp %h got %h", fidx + 1, want, shreg[15:0]);
            err_count++;
        end
        if (fidx == NUM_AXES - 1) begin
            fidx = 0;
            sets_done++;            // whole set decoded
        end else begin
            fidx++;
        end
    endtask

    initial begin
        err_count = 0;
        sets_done = 0;
        fidx      = 0;
        cur_set   = '0;
    end

    // ------------------------------------------------------------------------
    // sample on sysclk, DUT outputs are all registered
    // ------------------------------------------------------------------------
    always @(posedge sysclk) begin
        if (rst) begin
            sclk_q <= 1'b0;
            csel_q <= 1'b1;
            nbits  <= 0;
        end else begin
            sclk_q <= dac_sclk;
            csel_q <= dac_csel;
            if (push_dac) exp_q.push_back(exp_dac);
            if (chk_read && (reg_rdata !== exp_rdata)) begin
                $display("[ERROR] reg_rdata exp %h got %h", exp_rdata, reg_rdata);
                err_count++;
            end
            if (chk_dis && (amp_disable !== exp_dis)) begin
                $display("[ERROR] amp_disable exp %h got %h", exp_dis, amp_disable);
                err_count++;
            end
            if (dac_sclk && !sclk_q) begin
                shreg <= {shreg[DAC_FRAME_BITS-2:0], dac_mosi};  // rising sclk
                nbits <= nbits + 1;
            end
            if (dac_csel && !csel_q) begin
                check_frame();          // csel rise closes a frame
                nbits <= 0;
            end
        end
    end

endmodule

/* tb/motor_ctrl_tests.txt */
# W addr data blk | R addr expect | F axis value | C ampmask pwr | D cmd1 cmd2 cmd3 cmd4
# X mask (after 20 cycles) | I idle_cycles | E test_name ; all numbers hex except I
W 0011 00009000 0
R 0011 00009000
R 0014 10009000
W 0001 00001234 0
W 0051 00001234 0
W 1011 00001234 0
R 0001 00000000
R 0051 00000000
R 1011 00000000
R 0021 00008000
E cmd_readback
F 2 8123
R 0020 00008123
F 2 8000
E adc_readback
W 0021 00007000 0
W 0031 00008800 0
W 0041 00008001 1
D 9000 7000 8800 8001
W 0011 0000a000 0
I 250
E dac_commit
W 0011 00008100 1
I 10
W 0021 00008200 1
W 0031 00008300 1
D 8100 7000 8800 8001
D 8100 8200 8300 8001
I 250
E commit_busy
F 3 8a00
X 0
F 3 7600
X 0
F 3 8a01
X 4
R 0034 00008300
F 3 8000
X 4
E over_current
F 4 8500
X c
F 4 8000
C 8 0
X 4
C 0 1
X 0
R 0034 10008300
E clear

/* tb/tb_motor_ctrl.sv */
module tb_motor_ctrl;

    import qla_pkg::*;

    localparam int    HALF_PERIOD  = 20;
    localparam int    LINE_CYCLES  = 300;   // timeout budget per file line
    localparam int    DAC_DEADLINE = 400;   // cycles to wait for one frame set
    localparam string TEST_FILE    = "tb/motor_ctrl_tests.txt";

    logic                 sysclk;
    logic                 rst;
    logic                 reg_wen;
    logic                 blk_wen;
    addr_t                reg_waddr;
    data_t                reg_wdata;
    addr_t                reg_raddr;
    data_t                reg_rdata;
    cur_t [NUM_AXES-1:0]  cur_fb;
    cur_t [NUM_AXES-1:0]  fb_base;          // feedback without noise
    logic                 pwr_enable_cmd;
    axis_mask_t           amp_enable_cmd;
    axis_mask_t           amp_disable;
    logic                 dac_sclk;
    logic                 dac_mosi;
    logic                 dac_csel;

    // checker side
    logic                 chk_read;
    data_t                exp_rdata;
    logic                 chk_dis;
    axis_mask_t           exp_dis;
    logic                 push_dac;
    logic [63:0]          exp_dac;
    int                   err_count;
    int                   sets_done;

    integer               seed = 32'h0e1fd9ed;
    int                   cycles;
    int                   limit;
    int                   misc_errs;        // failures seen by the stimulus side
    int                   sets_used;

    motor_ctrl_top u_dut (
        .sysclk         (sysclk),
        .rst            (rst),
        .reg_wen        (reg_wen),
        .blk_wen        (blk_wen),
        .reg_waddr      (reg_waddr),
        .reg_wdata      (reg_wdata),
        .reg_raddr      (reg_raddr),
        .reg_rdata      (reg_rdata),
        .cur_fb         (cur_fb),
        .pwr_enable_cmd (pwr_enable_cmd),
        .amp_enable_cmd (amp_enable_cmd),
        .amp_disable    (amp_disable),
        .dac_sclk       (dac_sclk),
        .dac_mosi       (dac_mosi),
        .dac_csel       (dac_csel)
    );

    motor_ctrl_checker u_chk (
        .sysclk      (sysclk),
        .rst         (rst),
        .dac_sclk    (dac_sclk),
        .dac_mosi    (dac_mosi),
        .dac_csel    (dac_csel),
        .amp_disable (amp_disable),
        .reg_rdata   (reg_rdata),
        .chk_read    (chk_read),
        .exp_rdata   (exp_rdata),
        .chk_dis     (chk_dis),
        .exp_dis     (exp_dis),
        .push_dac    (push_dac),
        .exp_dac     (exp_dac),
        .err_count   (err_count),
        .sets_done   (sets_done)
    );

    initial sysclk = 1'b0;
    always #HALF_PERIOD sysclk = ~sysclk;

    // ------------------------------------------------------------------------
    // run limit from the length of the test file
    // ------------------------------------------------------------------------
    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("run stopped after %0d cycles without reaching the end", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic host_write(addr_t a, data_t d, logic b);
        @(negedge sysclk);
        reg_wen   = 1'b1;
        blk_wen   = b;
        reg_waddr = a;
        reg_wdata = d;
        @(negedge sysclk);
        reg_wen   = 1'b0;
        blk_wen   = 1'b0;
    endtask

    // noise only on idle axes other than the one being read
    task automatic host_read(addr_t a, data_t e);
        int n;
        @(negedge sysclk);
        reg_raddr = a;
        for (int i = 0; i < NUM_AXES; i++) begin
            n = $random(seed) % 65;             // -0x40 .. 0x40
            if (i != int'(a[7:4]) - 1 && fb_base[i] == CUR_MIDSCALE)
                cur_fb[i] = cur_t'(int'(fb_base[i]) + n);
        end
        @(negedge sysclk);
        chk_read  = 1'b1;
        exp_rdata = e;
        @(negedge sysclk);
        chk_read  = 1'b0;
        cur_fb    = fb_base;
    endtask

    task automatic expect_dac(logic [63:0] v);
        int waited;
        @(negedge sysclk);
        push_dac = 1'b1;
        exp_dac  = v;
        @(negedge sysclk);
        push_dac = 1'b0;
        waited   = 0;
        while (sets_done <= sets_used && waited < DAC_DEADLINE) begin
            @(negedge sysclk);
            waited++;
        end
        if (sets_done <= sets_used) begin
            $display("no DAC frame set arrived within %0d cycles", DAC_DEADLINE);
            misc_errs++;
        end
        sets_used++;
    endtask

    task automatic expect_disable(axis_mask_t m);
        repeat (20) @(negedge sysclk);
        chk_dis = 1'b1;
        exp_dis = m;
        @(negedge sysclk);
        chk_dis = 1'b0;
    endtask

    initial begin
        int          fd;
        int          r;
        int          nlines;
        int          ntests;
        int          nfail;
        int          errs_before;
        int          errs_now;
        logic [1023:0] line;
        logic [63:0] op;
        logic [127:0] name;         // room for the longest test name
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;

        reg_wen        = 0;
        blk_wen        = 0;
        reg_waddr      = '0;
        reg_wdata      = '0;
        reg_raddr      = '0;
        pwr_enable_cmd = 0;
        amp_enable_cmd = '0;
        fb_base  = {NUM_AXES{CUR_MIDSCALE}};
        cur_fb   = fb_base;
        chk_read    = 0;
        exp_rdata   = '0;
        chk_dis     = 0;
        exp_dis     = '0;
        push_dac    = 0;
        exp_dac     = '0;
        cycles      = 0;
        limit       = 0;
        misc_errs   = 0;
        sets_used   = 0;
        ntests      = 0;
        nfail       = 0;
        errs_before = 0;
        nlines      = 0;
        rst = 1'b1;

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", TEST_FILE);
            $display("TEST FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r > 0) nlines++;
            end
            $fclose(fd);
            limit = nlines * LINE_CYCLES;

            repeat (2) @(posedge sysclk);
            @(negedge sysclk);
            rst = 1'b0;

            fd = $fopen(TEST_FILE, "r");
            while (!$feof(fd)) begin
                line = '0;
                r = $fgets(line, fd);
                op = '0;
                if (r > 0) r = $sscanf(line, "%s", op);
                if (r <= 0 || op == "#") continue;      // blank or comment
                if (op == "W") begin
                    r = $sscanf(line, "%s %h %h %h", op, f1, f2, f3);
                    host_write(addr_t'(f1), f2, f3[0]);
                end else if (op == "R") begin
                    r = $sscanf(line, "%s %h %h", op, f1, f2);
                    host_read(addr_t'(f1), f2);
                end else if (op == "F") begin
                    r = $sscanf(line, "%s %h %h", op, f1, f2);
                    @(negedge sysclk);
                    fb_base[f1 - 1] = cur_t'(f2);       // axis numbered from 1
                    cur_fb = fb_base;
                end else if (op == "C") begin
                    r = $sscanf(line, "%s %h %h", op, f1, f2);
                    @(negedge sysclk);
                    amp_enable_cmd = axis_mask_t'(f1);
                    pwr_enable_cmd = f2[0];
                    @(negedge sysclk);
                    amp_enable_cmd = '0;
                    pwr_enable_cmd = 1'b0;
                end else if (op == "D") begin
                    r = $sscanf(line, "%s %h %h %h %h", op, f1, f2, f3, f4);
                    expect_dac({f1[15:0], f2[15:0], f3[15:0], f4[15:0]});
                end else if (op == "X") begin
                    r = $sscanf(line, "%s %h", op, f1);
                    expect_disable(axis_mask_t'(f1));
                end else if (op == "I") begin
                    r = $sscanf(line, "%s %d", op, f1);
                    repeat (f1) @(negedge sysclk);
                end else if (op == "E") begin
                    r = $sscanf(line, "%s %s", op, name);
                    errs_now = err_count + misc_errs;
                    ntests++;
                    if (errs_now != errs_before) nfail++;
                    $display("test %0s: %0s (%0d errors)", name,
                             (errs_now == errs_before) ? "ok" : "failed",
                             errs_now - errs_before);
                    errs_before = errs_now;
                end else begin
                    $display("unknown command %0s in %s", op, TEST_FILE);
                    misc_errs++;
                end
            end
            $fclose(fd);

            $display("tests %0d, failed %0d, errors %0d", ntests, nfail,
                     err_count + misc_errs);
            if (err_count + misc_errs == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

/* vlog.f */
src/qla_pkg.sv
src/cmd_write_decode.sv
src/axis_channel.sv
src/dac_shifter.sv
src/reg_read_mux.sv
src/motor_ctrl_top.sv
tb/motor_ctrl_checker.sv
tb/tb_motor_ctrl.sv
